// ==== design/frame_defines.svh ====
`ifndef FRAME_DEFINES_SVH
`define FRAME_DEFINES_SVH

// shrunk raster with horizontal counts in pixel clocks
`define H_ACTIVE 64       // visible pixels per line
`define H_SYNC_START 72   // first hsync cycle
`define H_SYNC_END 80     // first cycle after hsync
`define H_TOTAL 96        // cycles per line

// vertical in lines
`define V_ACTIVE 8        // visible lines
`define V_SYNC_START 9    // vsync line
`define V_SYNC_END 10     // first line after vsync
`define V_TOTAL 12        // lines per frame

`define HCOUNT_BITS 7
`define VCOUNT_BITS 4

// frame store layout with two blocks per visible line
`define PIXEL_BITS 16      // top nibble unused
`define BLOCK_PIXELS 32
`define BLOCK_BITS 512     // BLOCK_PIXELS * PIXEL_BITS
`define BLOCK_ADDR_BITS 4  // 16 blocks

// test pattern with exclusive bounds
`define BAND_TOP 4
`define BAND_BOTTOM 7
`define BOX_LEFT 20
`define BOX_RIGHT 30
`define BOX_TOP 1
`define BOX_BOTTOM 6
`define COLOR_BAND 16'h0f0f  // magenta
`define COLOR_BOX 16'h000f   // blue
`define COLOR_BACK 16'h0ff0  // red f green f blue 0 after unpack

`endif

// ==== design/frame_pkg.sv ====
`include "frame_defines.svh"

package frame_pkg;

  // rgb decode of a stored word, pad nibble on top
  typedef struct packed {
    logic [3:0] pad;
    logic [3:0] red;
    logic [3:0] green;
    logic [3:0] blue;
  } pixel_rgb_t;

  // writer fills raw, scanout pulls rgb
  typedef union packed {
    logic [`PIXEL_BITS-1:0] raw;
    pixel_rgb_t rgb;
  } pixel_word_u;

  // pixel 0 in the low bits
  typedef pixel_word_u [`BLOCK_PIXELS-1:0] block_t;

  typedef struct packed {
    logic strobe;                       // one cycle pulse
    logic [`BLOCK_ADDR_BITS-1:0] addr;  // line * 2 + block in line
    block_t data;
  } block_write_t;

  typedef struct packed {
    logic strobe;
    logic [`BLOCK_ADDR_BITS-1:0] addr;
  } block_read_req_t;

  // syncs active high in here, inverted at the pins
  typedef struct packed {
    logic [`HCOUNT_BITS-1:0] hcount;
    logic [`VCOUNT_BITS-1:0] vcount;
    logic hsync;
    logic vsync;
    logic blank;
  } raster_t;

endpackage

// ==== design/pattern_writer.sv ====
`timescale 1ns/1ps
`include "frame_defines.svh"

module pattern_writer (
  input  logic                     pix_clk,
  input  logic                     sys_rst,
  output frame_pkg::block_write_t  wr
);

  logic [`HCOUNT_BITS-1:0] x;  // column in visible area
  logic [`VCOUNT_BITS-1:0] y;  // row
  logic [$clog2(`BLOCK_PIXELS)-1:0] slot;  // position inside current block
  logic last;                               // pixel 31 of a block
  frame_pkg::pixel_word_u pix;
  frame_pkg::pixel_word_u [`BLOCK_PIXELS-2:0] collect;  // pixels 0..30
  logic [`BLOCK_ADDR_BITS-1:0] base_addr;               // latched at pixel 0

  assign slot = x[$clog2(`BLOCK_PIXELS)-1:0];
  assign last = (slot == `BLOCK_PIXELS - 1);

  // pattern rule, band beats box
  always_comb begin
    if ((y > `BAND_TOP) && (y < `BAND_BOTTOM)) begin
      pix.raw = `COLOR_BAND;
    end else if ((x > `BOX_LEFT) && (x < `BOX_RIGHT) &&
                 (y > `BOX_TOP) && (y < `BOX_BOTTOM)) begin
      pix.raw = `COLOR_BOX;
    end else begin
      pix.raw = `COLOR_BACK;
    end
  end

  // walk the visible area only, one pixel a cycle
  always_ff @(posedge pix_clk) begin
    if (sys_rst) begin
      x <= '0;
      y <= '0;
    end else if (x == `H_ACTIVE - 1) begin
      x <= '0;
      y <= (y == `V_ACTIVE - 1) ? '0 : y + 1'b1;  // full frame every 512 cycles
    end else begin
      x <= x + 1'b1;
    end
  end

  // gather block, ship it on the last pixel
  always_ff @(posedge pix_clk) begin
    if (sys_rst) begin
      wr.strobe <= 1'b0;
    end else begin
      wr.strobe <= last;  // pulses the cycle after pixel 31
    end
    if (slot == '0) begin
      base_addr <= `BLOCK_ADDR_BITS'(y * (`H_ACTIVE / `BLOCK_PIXELS) + x / `BLOCK_PIXELS);
    end
    if (!last) begin
      collect[slot] <= pix;
    end else begin
      wr.addr <= base_addr;
      wr.data <= {pix, collect};  // newest pixel on top
    end
  end

  // one block per 32 cycles, so never back to back
  a_strobe_single : assert property (@(posedge pix_clk) disable iff (sys_rst)
    wr.strobe |=> !wr.strobe);

endmodule

// ==== design/block_store.sv ====
`timescale 1ns/1ps
`include "frame_defines.svh"

// on-chip stand-in for the frame dram
module block_store (
  input  logic                       pix_clk,
  input  logic                       sys_rst,
  input  frame_pkg::block_write_t    wr,
  input  frame_pkg::block_read_req_t rd_req,
  output frame_pkg::block_t          rd_data,
  output logic                       rd_valid
);

  localparam int NUM_BLOCKS = 1 << `BLOCK_ADDR_BITS;

  frame_pkg::block_t mem [0:NUM_BLOCKS-1];

  // write port always accepts
  always_ff @(posedge pix_clk) begin
    if (sys_rst) begin
      for (int i = 0; i < NUM_BLOCKS; i++) begin
        mem[i] <= '0;  // all blocks cleared
      end
    end else if (wr.strobe) begin
      mem[wr.addr] <= wr.data;
    end
  end

  // one cycle read port
  // same-edge write to same addr gives the old block
  always_ff @(posedge pix_clk) begin
    if (sys_rst) begin
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= rd_req.strobe;
    end
    if (rd_req.strobe) begin
      rd_data <= mem[rd_req.addr];
    end
  end

  // scanout counts on a one cycle turnaround for single cycle requests
  a_read_latency : assert property (@(posedge pix_clk) disable iff (sys_rst)
    rd_req.strobe |=> (rd_valid && !rd_req.strobe));

endmodule

// ==== design/vga_timing.sv ====
`timescale 1ns/1ps
`include "frame_defines.svh"

module vga_timing (
  input  logic                pix_clk,
  input  logic                sys_rst,
  output frame_pkg::raster_t  raster
);

  logic [`HCOUNT_BITS-1:0] h_next;
  logic [`VCOUNT_BITS-1:0] v_next;

  // next position, line then frame wrap
  always_comb begin
    if (raster.hcount == `H_TOTAL - 1) begin
      h_next = '0;
      if (raster.vcount == `V_TOTAL - 1) begin
        v_next = '0;
      end else begin
        v_next = raster.vcount + 1'b1;
      end
    end else begin
      h_next = raster.hcount + 1'b1;
      v_next = raster.vcount;
    end
  end

  // sync and blank decoded from the next position
  // so they line up with the registered counters
  always_ff @(posedge pix_clk) begin
    if (sys_rst) begin
      raster <= '0;  // (0,0) is visible, no sync
    end else begin
      raster.hcount <= h_next;
      raster.vcount <= v_next;
      raster.hsync  <= (h_next >= `H_SYNC_START) && (h_next < `H_SYNC_END);
      raster.vsync  <= (v_next >= `V_SYNC_START) && (v_next < `V_SYNC_END);
      raster.blank  <= (h_next >= `H_ACTIVE) || (v_next >= `V_ACTIVE);
    end
  end

  // scanout lookahead relies on the wrap point
  a_hcount_range : assert property (@(posedge pix_clk) disable iff (sys_rst)
    raster.hcount < `H_TOTAL);

endmodule

// ==== design/scanout.sv ====
`timescale 1ns/1ps
`include "frame_defines.svh"

module scanout (
  input  logic                       pix_clk,
  input  logic                       sys_rst,
  input  frame_pkg::raster_t         raster,
  output frame_pkg::block_read_req_t rd_req,
  input  frame_pkg::block_t          rd_data,
  input  logic                       rd_valid,
  output logic [3:0]                 vga_r,
  output logic [3:0]                 vga_g,
  output logic [3:0]                 vga_b,
  output logic                       vga_hs,
  output logic                       vga_vs
);

  logic [`HCOUNT_BITS:0] ahead_h;     // hcount + 2, may run past the line
  logic [`HCOUNT_BITS-1:0] look_h;    // wrapped lookahead column
  logic [`VCOUNT_BITS-1:0] look_v;    // line of the lookahead column
  logic [$clog2(`BLOCK_PIXELS)-1:0] idx;
  logic swap;                         // block start on a visible line
  logic shadow_full;                  // shadow loaded since last swap
  frame_pkg::block_t live;            // block on screen
  frame_pkg::block_t shadow;          // next block, prefetched
  frame_pkg::pixel_word_u pix;

  // prefetch two cycles ahead: request, store turnaround, then swap
  always_comb begin
    ahead_h = {1'b0, raster.hcount} + {{(`HCOUNT_BITS - 1){1'b0}}, 2'd2};
    if (ahead_h >= `H_TOTAL) begin
      look_h = `HCOUNT_BITS'(ahead_h - `H_TOTAL);
      // block 0 of the next line, line 0 after the last one
      if (raster.vcount == `V_TOTAL - 1) begin
        look_v = '0;
      end else begin
        look_v = raster.vcount + 1'b1;
      end
    end else begin
      look_h = ahead_h[`HCOUNT_BITS-1:0];
      look_v = raster.vcount;
    end
    rd_req.strobe = (look_h[$clog2(`BLOCK_PIXELS)-1:0] == '0) &&
                    (look_h < `H_ACTIVE) && (look_v < `V_ACTIVE);
    rd_req.addr   = `BLOCK_ADDR_BITS'(look_v * (`H_ACTIVE / `BLOCK_PIXELS) +
                                      look_h / `BLOCK_PIXELS);
  end

  assign idx  = raster.hcount[$clog2(`BLOCK_PIXELS)-1:0];
  assign swap = !raster.blank && (idx == '0);

  // live only takes the new block at the swap edge, so read shadow then
  assign pix = swap ? shadow[idx] : live[idx];

  always_ff @(posedge pix_clk) begin
    if (sys_rst) begin
      live        <= '0;
      shadow      <= '0;
      shadow_full <= 1'b1;  // zero shadow stands in for the missed first fetch
    end else begin
      if (rd_valid) begin
        shadow <= rd_data;
      end
      if (swap) begin
        live <= shadow;
      end
      if (rd_valid) begin
        shadow_full <= 1'b1;
      end else if (swap) begin
        shadow_full <= 1'b0;
      end
    end
  end

  // pins, one cycle behind the raster
  always_ff @(posedge pix_clk) begin
    if (sys_rst) begin
      vga_r  <= '0;
      vga_g  <= '0;
      vga_b  <= '0;
      vga_hs <= 1'b1;  // active low
      vga_vs <= 1'b1;
    end else begin
      vga_r  <= raster.blank ? 4'h0 : pix.rgb.red;
      vga_g  <= raster.blank ? 4'h0 : pix.rgb.green;
      vga_b  <= raster.blank ? 4'h0 : pix.rgb.blue;
      vga_hs <= ~raster.hsync;
      vga_vs <= ~raster.vsync;
    end
  end

  // the store read issued two cycles earlier must have landed
  a_swap_loaded : assert property (@(posedge pix_clk) disable iff (sys_rst)
    swap |-> shadow_full);

endmodule

// ==== design/frame_top.sv ====
`timescale 1ns/1ps
`include "frame_defines.svh"

module frame_top (
  input  logic       pix_clk,
  input  logic       sys_rst,
  output logic [3:0] vga_r,
  output logic [3:0] vga_g,
  output logic [3:0] vga_b,
  output logic       vga_hs,
  output logic       vga_vs
);

  frame_pkg::block_write_t    wr;       // writer into store
  frame_pkg::block_read_req_t rd_req;   // scanout prefetch
  frame_pkg::block_t          rd_data;
  logic                       rd_valid;
  frame_pkg::raster_t         raster;

  pattern_writer writer (
    .pix_clk (pix_clk),
    .sys_rst (sys_rst),
    .wr      (wr)
  );

  block_store store (
    .pix_clk  (pix_clk),
    .sys_rst  (sys_rst),
    .wr       (wr),
    .rd_req   (rd_req),
    .rd_data  (rd_data),
    .rd_valid (rd_valid)
  );

  vga_timing timing (
    .pix_clk (pix_clk),
    .sys_rst (sys_rst),
    .raster  (raster)
  );

  scanout scan (
    .pix_clk  (pix_clk),
    .sys_rst  (sys_rst),
    .raster   (raster),
    .rd_req   (rd_req),
    .rd_data  (rd_data),
    .rd_valid (rd_valid),
    .vga_r    (vga_r),
    .vga_g    (vga_g),
    .vga_b    (vga_b),
    .vga_hs   (vga_hs),
    .vga_vs   (vga_vs)
  );

endmodule

// ==== bench/clock_gen.sv ====
`timescale 1ns/1ps

// 100 ns pixel clock, reset held for the first 4 rising edges
module clock_gen (
  output logic pix_clk,
  output logic sys_rst
);

  initial begin
    pix_clk = 1'b0;
    forever #50 pix_clk = ~pix_clk;  // 50 ns half period
  end

  initial begin
    sys_rst = 1'b1;
    repeat (4) @(posedge pix_clk);
    #1 sys_rst = 1'b0;  // released just after the 4th edge
  end

endmodule

// ==== bench/frame_tb.sv ====
`timescale 1ns/1ps
`include "frame_defines.svh"

module frame_tb;

  localparam int CHECKED_FRAMES = 3;
  localparam int TIMEOUT_NS = 4 * `H_TOTAL * `V_TOTAL * 100 + 10000;  // 4 frames + slack

  logic       pix_clk;
  logic       sys_rst;
  logic [3:0] vga_r;
  logic [3:0] vga_g;
  logic [3:0] vga_b;
  logic       vga_hs;
  logic       vga_vs;

  // first checked frame, which later frames must repeat
  frame_pkg::pixel_word_u first_frame [0:`V_ACTIVE-1][0:`H_ACTIVE-1];

  clock_gen clocks (
    .pix_clk (pix_clk),
    .sys_rst (sys_rst)
  );

  frame_top UUT (
    .pix_clk (pix_clk),
    .sys_rst (sys_rst),
    .vga_r   (vga_r),
    .vga_g   (vga_g),
    .vga_b   (vga_b),
    .vga_hs  (vga_hs),
    .vga_vs  (vga_vs)
  );

  // band beats box beats background
  function automatic frame_pkg::pixel_word_u expected_pixel(input int x, input int y);
    frame_pkg::pixel_word_u w;
    if ((y > `BAND_TOP) && (y < `BAND_BOTTOM)) begin
      w.raw = `COLOR_BAND;
    end else if ((x > `BOX_LEFT) && (x < `BOX_RIGHT) &&
                 (y > `BOX_TOP) && (y < `BOX_BOTTOM)) begin
      w.raw = `COLOR_BOX;
    end else begin
      w.raw = `COLOR_BACK;
    end
    return w;
  endfunction

  task automatic stop_with_failure();
    $display("FAIL: see errors above");
    $fatal(1, "run stopped at the first error");
  endtask

  // the pad nibble never reaches the pins
  task automatic check_color(input string name, input frame_pkg::pixel_word_u expected,
                             input frame_pkg::pixel_word_u actual);
    if ((expected.rgb.red !== actual.rgb.red) || (expected.rgb.green !== actual.rgb.green) ||
        (expected.rgb.blue !== actual.rgb.blue)) begin
      $display("Fail %s: expected rgb %h%h%h, actual rgb %h%h%h", name,
               expected.rgb.red, expected.rgb.green, expected.rgb.blue,
               actual.rgb.red, actual.rgb.green, actual.rgb.blue);
      stop_with_failure();
    end
  endtask

  task automatic check_sync(input string name, input logic expected, input logic actual);
    if (expected !== actual) begin
      $display("Fail %s: expected %h, actual %h", name, expected, actual);
      stop_with_failure();
    end
  endtask

  // sampled mid cycle on the falling edge
  initial begin : compare_outputs
    int count;       // samples from reset to lock
    int x;
    int y;
    int frame;       // 0 is the frame shown from reset
    logic prev_vs;
    logic locked;    // position known from vsync
    string where;
    frame_pkg::pixel_word_u actual;
    frame_pkg::pixel_word_u blank_word;
    count = 0;
    x = 0;
    y = 0;
    frame = 0;
    prev_vs = 1'b1;
    locked = 1'b0;
    blank_word.raw = '0;
    @(posedge pix_clk);
    while (sys_rst) begin
      @(negedge pix_clk);
      check_sync("vga_hs in reset", 1'b1, vga_hs);  // syncs idle high
      check_sync("vga_vs in reset", 1'b1, vga_vs);
    end
    while (frame <= CHECKED_FRAMES) begin
      @(negedge pix_clk);
      actual.raw = {4'h0, vga_r, vga_g, vga_b};
      if (!locked) begin
        if (prev_vs && !vga_vs) begin
          // vsync falls at pixel 0 of line V_SYNC_START
          if (count != `V_SYNC_START * `H_TOTAL) begin
            $display("first vsync came %0d samples after reset, not %0d",
                     count, `V_SYNC_START * `H_TOTAL);
            stop_with_failure();
          end
          locked = 1'b1;
          x = 0;
          y = `V_SYNC_START;
        end else begin
          check_sync("vga_vs before first vsync", 1'b1, vga_vs);
          if (count < `H_SYNC_START) begin
            check_sync("vga_hs on first line", 1'b1, vga_hs);
          end
          count++;
        end
      end else begin
        x++;
        if (x == `H_TOTAL) begin
          x = 0;
          y = (y == `V_TOTAL - 1) ? 0 : y + 1;
        end
        if ((x == 0) && (y == 0)) begin
          frame++;  // row 0 starts V_TOTAL - V_SYNC_START lines after vsync
        end
      end
      prev_vs = vga_vs;
      if (locked && (frame <= CHECKED_FRAMES)) begin
        where = $sformatf("at x %0d y %0d frame %0d", x, y, frame);
        check_sync({"vga_hs ", where}, !((x >= `H_SYNC_START) && (x < `H_SYNC_END)), vga_hs);
        check_sync({"vga_vs ", where}, !((y >= `V_SYNC_START) && (y < `V_SYNC_END)), vga_vs);
        if ((x >= `H_ACTIVE) || (y >= `V_ACTIVE)) begin
          check_color({"vga_rgb blanking ", where}, blank_word, actual);
        end else if (frame == 1) begin
          check_color({"vga_rgb ", where}, expected_pixel(x, y), actual);
          first_frame[y][x] = actual;
        end else if (frame >= 2) begin
          check_color({"vga_rgb vs first frame ", where}, first_frame[y][x], actual);
        end
      end
    end
    $display("PASS: all tests");
    $finish;
  end

  initial begin : watchdog
    #(TIMEOUT_NS);
    $display("timeout: the frames were not all checked after %0d ns", TIMEOUT_NS);
    stop_with_failure();
  end

endmodule

// ==== all.f ====
+incdir+design
design/frame_pkg.sv
design/pattern_writer.sv
design/block_store.sv
design/vga_timing.sv
design/scanout.sv
design/frame_top.sv
bench/clock_gen.sv
bench/frame_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build with verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f all.f --top-module frame_tb \
  -o frame_sim > build.log 2>&1 \
  && ./obj_dir/frame_sim > sim.log 2>&1 \
  || { cat build.log sim.log 2>/dev/null; echo "build or simulation error"; }
cat sim.log 2>/dev/null
grep -qx "PASS: all tests" sim.log \
  && { echo "simulation passed"; exit 0; } \
  || { echo "simulation failed"; exit 1; }
